/* common/mem_prot_pkg.sv */
/* memory access and protection result structs, fixed PMA region table,
   PMP config byte layout */
`default_nettype none

package mem_prot_pkg;

    localparam logic [1:0] WIDTH_WORD = 2'b10; // 0 byte, 1 half, 2 word

    typedef struct packed {
        logic [31:0] addr;
        logic [1:0]  width;
        logic        ren;
        logic        wen;
        logic        xen;
    } mem_acc_t;

    typedef struct packed {
        logic i_fault;
        logic l_fault;
        logic s_fault;
    } prot_res_t;

    typedef struct packed {
        logic [31:0] base;
        logic [31:0] limit; // inclusive
        logic        r;
        logic        w;
        logic        x;
        logic        word_only;
    } pma_region_t;

    localparam int PMA_NUM = 3;

    // base, limit, r, w, x, word_only
    localparam pma_region_t PMA_REGIONS [PMA_NUM] = '{
        '{32'h0000_0000, 32'h0000_FFFF, 1'b1, 1'b0, 1'b1, 1'b0},  // rom
        '{32'h8000_0000, 32'h8000_FFFF, 1'b1, 1'b1, 1'b1, 1'b0},  // ram
        '{32'h4000_0000, 32'h4000_0FFF, 1'b1, 1'b1, 1'b0, 1'b1}   // io
    };

    typedef enum logic [1:0] {PMP_OFF = 2'b00, PMP_TOR = 2'b01} pmp_mode_t;

    typedef struct packed {
        logic      lock;
        logic [1:0] rsvd;
        pmp_mode_t mode;
        logic      x;
        logic      w;
        logic      r;
    } pmp_cfg_t;

    localparam int PMP_ENTRIES = 4;

endpackage

`default_nettype wire

/* common/priv_types_pkg.sv */
/* privilege levels, mstatus layout, CSR addresses, trap cause codes,
   CSR request/response, exception and trap structs */
`default_nettype none

package priv_types_pkg;

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        M_MODE = 2'b11
    } priv_level_t;

    // laid out as the architectural mstatus word
    typedef struct packed {
        logic [9:0]  rsvd_31_22;
        logic        tw;
        logic [7:0]  rsvd_20_13;
        priv_level_t mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    localparam logic [11:0] MSTATUS  = 12'h300;
    localparam logic [11:0] MIE      = 12'h304;
    localparam logic [11:0] MTVEC    = 12'h305;
    localparam logic [11:0] MEPC     = 12'h341;
    localparam logic [11:0] MCAUSE   = 12'h342;
    localparam logic [11:0] MTVAL    = 12'h343;
    localparam logic [11:0] MIP      = 12'h344;
    localparam logic [11:0] MHARTID  = 12'hF14;
    localparam logic [11:0] PMPCFG0  = 12'h3A0;
    localparam logic [11:0] PMPADDR0 = 12'h3B0;
    localparam logic [11:0] PMPADDR3 = 12'h3B3;

    localparam logic [31:0] CAUSE_INSN_FAULT  = 32'd1;
    localparam logic [31:0] CAUSE_ILLEGAL     = 32'd2;
    localparam logic [31:0] CAUSE_BREAKPOINT  = 32'd3;
    localparam logic [31:0] CAUSE_LOAD_FAULT  = 32'd5;
    localparam logic [31:0] CAUSE_STORE_FAULT = 32'd7;
    localparam logic [31:0] CAUSE_ECALL_U     = 32'd8;
    localparam logic [31:0] CAUSE_ECALL_M     = 32'd11;
    localparam logic [31:0] CAUSE_SOFT_INT    = 32'h8000_0003;
    localparam logic [31:0] CAUSE_TIMER_INT   = 32'h8000_0007;
    localparam logic [31:0] CAUSE_EXT_INT     = 32'h8000_000B;

    localparam logic [31:0] HART_ID     = 32'd0;
    localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;

    typedef enum logic [1:0] {CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_t;

    typedef struct packed {
        logic [11:0] addr;
        csr_op_t     op;
        logic [31:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } csr_rsp_t;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        breakpoint;
        logic        ecall;
        logic        mret;
        logic [31:0] epc;
        logic [31:0] badaddr;
    } exc_t;

    typedef struct packed {
        logic        take;
        logic        is_interrupt;
        logic [31:0] cause;
        logic [31:0] epc;
        logic [31:0] tval;
        logic        mret;
    } trap_t;

endpackage

`default_nettype wire

/* mem_prot/priv_pma.sv */
/* physical memory attribute check of instruction and data accesses
   against the fixed region table */
`timescale 1ns/1ns
`default_nettype none

module priv_pma import mem_prot_pkg::*; (
    input  mem_acc_t  iacc,
    input  mem_acc_t  dacc,
    output prot_res_t pma_res
);

    // no matching region is a fault as well
    function automatic logic region_fault(input logic [31:0] addr, input logic [1:0] width,
                                          input logic rd, input logic wr, input logic ex);
        logic fault;
        fault = 1'b1;
        for (int i = 0; i < PMA_NUM; i++) begin
            if (addr >= PMA_REGIONS[i].base && addr <= PMA_REGIONS[i].limit)
                fault = (rd && !PMA_REGIONS[i].r) || (wr && !PMA_REGIONS[i].w)
                     || (ex && !PMA_REGIONS[i].x)
                     || (PMA_REGIONS[i].word_only && width != WIDTH_WORD);
        end
        return fault;
    endfunction

    assign pma_res.i_fault = iacc.xen && region_fault(iacc.addr, iacc.width, 1'b0, 1'b0, 1'b1);
    assign pma_res.l_fault = dacc.ren && region_fault(dacc.addr, dacc.width, 1'b1, 1'b0, 1'b0);
    assign pma_res.s_fault = dacc.wen && region_fault(dacc.addr, dacc.width, 1'b0, 1'b1, 1'b0);

endmodule

`default_nettype wire

/* mem_prot/priv_pmp.sv */
/* four-entry top-of-range PMP: config and address registers,
   CSR read port, access checks */
`timescale 1ns/1ns
`default_nettype none

module priv_pmp import priv_types_pkg::*, mem_prot_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic        pmp_wr,
    input  logic [11:0] pmp_waddr,
    input  logic [31:0] pmp_wdata,
    output logic [31:0] pmp_rdata,
    input  priv_level_t curr_mode,
    input  mem_acc_t    iacc,
    input  mem_acc_t    dacc,
    output prot_res_t   pmp_res
);

    pmp_cfg_t    pmp_cfg  [PMP_ENTRIES];
    logic [31:0] pmp_addr [PMP_ENTRIES];  // address bits 33:2

    // reserved bits read as zero, unsupported match modes fall back to OFF
    function automatic pmp_cfg_t legal_cfg(input logic [7:0] raw);
        pmp_cfg_t cfg;
        cfg      = raw;
        cfg.rsvd = 2'b00;
        if (raw[4:3] != 2'b01)
            cfg.mode = PMP_OFF;
        return cfg;
    endfunction

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < PMP_ENTRIES; i++) begin
                pmp_cfg[i]  <= '0;
                pmp_addr[i] <= 32'd0;
            end
        end else if (pmp_wr) begin
            for (int i = 0; i < PMP_ENTRIES; i++) begin
                if (!pmp_cfg[i].lock) begin  // locked until reset
                    if (pmp_waddr == PMPCFG0)
                        pmp_cfg[i] <= legal_cfg(pmp_wdata[8*i +: 8]);
                    if (pmp_waddr == PMPADDR0 + 12'(i))
                        pmp_addr[i] <= pmp_wdata;
                end
            end
        end
    end

    always_comb begin
        pmp_rdata = 32'd0;
        for (int i = 0; i < PMP_ENTRIES; i++) begin
            if (pmp_waddr == PMPCFG0)
                pmp_rdata[8*i +: 8] = pmp_cfg[i];
            if (pmp_waddr == PMPADDR0 + 12'(i))
                pmp_rdata = pmp_addr[i];
        end
    end

    // lowest matching entry wins; M mode passes unless that entry is locked
    function automatic logic acc_fault(input logic [31:0] addr,
                                       input logic rd, input logic wr, input logic ex);
        logic        matched;
        logic        allowed;
        logic [31:0] lower;
        matched = 1'b0;
        allowed = (curr_mode == M_MODE);
        lower   = 32'd0;
        for (int i = 0; i < PMP_ENTRIES; i++) begin
            if (!matched && pmp_cfg[i].mode == PMP_TOR
                    && {2'b00, addr[31:2]} >= lower && {2'b00, addr[31:2]} < pmp_addr[i]) begin
                matched = 1'b1;
                if (curr_mode == U_MODE || pmp_cfg[i].lock)
                    allowed = (!rd || pmp_cfg[i].r) && (!wr || pmp_cfg[i].w)
                           && (!ex || pmp_cfg[i].x);
            end
            lower = pmp_addr[i];
        end
        return !allowed;
    endfunction

    assign pmp_res.i_fault = iacc.xen && acc_fault(iacc.addr, 1'b0, 1'b0, 1'b1);
    assign pmp_res.l_fault = dacc.ren && acc_fault(dacc.addr, 1'b1, 1'b0, 1'b0);
    assign pmp_res.s_fault = dacc.wen && acc_fault(dacc.addr, 1'b0, 1'b1, 1'b0);

endmodule

`default_nettype wire

/* priv_block/priv_block.sv */
/* machine-level privilege unit top: CSR file, PMA and PMP checkers,
   trap controller */
`timescale 1ns/1ns
`default_nettype none

module priv_block import priv_types_pkg::*, mem_prot_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic        csr_valid,
    input  csr_req_t    csr_req,
    output logic        csr_ack,
    output csr_rsp_t    csr_rsp,
    input  mem_acc_t    iacc,
    input  mem_acc_t    dacc,
    output prot_res_t   prot_fault,
    input  exc_t        exc,
    input  logic        timer_int,
    input  logic        soft_int,
    input  logic        ext_int,
    output logic        insert_pc,
    output logic [31:0] priv_pc,
    output priv_level_t curr_mode
);

    trap_t       trap;
    mstatus_t    mstatus;
    logic [2:0]  int_pending;   // {ext, timer, soft}
    logic [2:0]  mie_en;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic        pmp_wr;
    logic [11:0] pmp_waddr;
    logic [31:0] pmp_wdata;
    logic [31:0] pmp_rdata;
    prot_res_t   pma_res;
    prot_res_t   pmp_res;

    priv_csr i_priv_csr (
        .CLK(CLK), .rst(rst),
        .csr_valid(csr_valid), .csr_req(csr_req), .csr_ack(csr_ack), .csr_rsp(csr_rsp),
        .timer_int(timer_int), .soft_int(soft_int), .ext_int(ext_int),
        .trap(trap), .int_pending(int_pending), .curr_mode(curr_mode),
        .mstatus(mstatus), .mie_en(mie_en), .mtvec(mtvec), .mepc(mepc),
        .pmp_wr(pmp_wr), .pmp_waddr(pmp_waddr), .pmp_wdata(pmp_wdata),
        .pmp_rdata(pmp_rdata)
    );

    priv_pma i_priv_pma (.iacc(iacc), .dacc(dacc), .pma_res(pma_res));

    priv_pmp i_priv_pmp (
        .CLK(CLK), .rst(rst),
        .pmp_wr(pmp_wr), .pmp_waddr(pmp_waddr), .pmp_wdata(pmp_wdata),
        .pmp_rdata(pmp_rdata), .curr_mode(curr_mode),
        .iacc(iacc), .dacc(dacc), .pmp_res(pmp_res)
    );

    priv_trap_ctrl i_priv_trap_ctrl (
        .CLK(CLK), .rst(rst),
        .exc(exc), .pma_res(pma_res), .pmp_res(pmp_res), .iacc(iacc), .dacc(dacc),
        .int_pending(int_pending), .mie_en(mie_en), .mstatus(mstatus),
        .curr_mode(curr_mode), .mtvec(mtvec), .mepc(mepc),
        .prot_fault(prot_fault), .trap(trap), .insert_pc(insert_pc), .priv_pc(priv_pc)
    );

endmodule

`default_nettype wire

/* priv_block/priv_csr.sv */
/* machine CSR file with four-phase req/ack access, privilege mode,
   interrupt pending latch, trap and mret state updates */
`timescale 1ns/1ns
`default_nettype none

module priv_csr import priv_types_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  logic        csr_valid,
    input  csr_req_t    csr_req,
    output logic        csr_ack,
    output csr_rsp_t    csr_rsp,
    input  logic        timer_int,
    input  logic        soft_int,
    input  logic        ext_int,
    input  trap_t       trap,
    output logic [2:0]  int_pending,   // {ext, timer, soft}
    output priv_level_t curr_mode,
    output mstatus_t    mstatus,
    output logic [2:0]  mie_en,
    output logic [31:0] mtvec,
    output logic [31:0] mepc,
    output logic        pmp_wr,
    output logic [11:0] pmp_waddr,
    output logic [31:0] pmp_wdata,
    input  logic [31:0] pmp_rdata
);

    logic [31:0] mcause;
    logic [31:0] mtval;
    logic        accept;
    logic        is_pmp;
    logic        known;
    logic        illegal;
    logic        do_write;
    logic [31:0] old_val;
    logic [31:0] new_val;

    // {ext, timer, soft} sit at bits 11, 7 and 3 of mie and mip
    function automatic logic [31:0] irq_word(input logic [2:0] bits);
        return {20'd0, bits[2], 3'd0, bits[1], 3'd0, bits[0], 3'd0};
    endfunction

    assign accept = csr_valid && !csr_ack;   // first cycle of a request
    assign is_pmp = (csr_req.addr == PMPCFG0) || (csr_req.addr inside {[PMPADDR0:PMPADDR3]});

    always_comb begin
        known = 1'b1;
        case (csr_req.addr)
            MSTATUS: old_val = mstatus;
            MIE:     old_val = irq_word(mie_en);
            MIP:     old_val = irq_word(int_pending);
            MTVEC:   old_val = mtvec;
            MEPC:    old_val = mepc;
            MCAUSE:  old_val = mcause;
            MTVAL:   old_val = mtval;
            MHARTID: old_val = HART_ID;
            default: begin
                old_val = pmp_rdata;
                known   = is_pmp;
            end
        endcase
    end

    always_comb begin
        case (csr_req.op)
            CSR_WRITE: new_val = csr_req.wdata;
            CSR_SET:   new_val = old_val | csr_req.wdata;
            CSR_CLEAR: new_val = old_val & ~csr_req.wdata;
            default:   new_val = old_val;
        endcase
    end

    assign illegal = !known || (curr_mode == U_MODE)
                   || ((csr_req.addr inside {MHARTID, MIP}) && csr_req.op != CSR_READ);
    assign do_write = accept && !illegal && csr_req.op != CSR_READ;

    // pmp registers live in the checker, written on the accepting edge
    assign pmp_wr    = do_write && is_pmp;
    assign pmp_waddr = csr_req.addr;
    assign pmp_wdata = new_val;

    always_ff @(posedge CLK) begin
        if (accept) begin
            csr_rsp.err   <= illegal;
            csr_rsp.rdata <= illegal ? 32'd0 : old_val;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            csr_ack     <= 1'b0;
            curr_mode   <= M_MODE;
            mstatus     <= '0;
            mie_en      <= 3'b000;
            int_pending <= 3'b000;
            mtvec       <= MTVEC_RESET;
            mepc        <= 32'd0;
            mcause      <= 32'd0;
            mtval       <= 32'd0;
        end else begin
            csr_ack     <= csr_valid;                  // held while valid, drops one edge later
            int_pending <= {ext_int, timer_int, soft_int};
            if (do_write) begin
                case (csr_req.addr)
                    MSTATUS: begin
                        mstatus.mie  <= new_val[3];
                        mstatus.mpie <= new_val[7];
                        mstatus.mpp  <= (new_val[12:11] == 2'b11) ? M_MODE : U_MODE;
                        mstatus.tw   <= new_val[21];
                    end
                    MIE:     mie_en <= {new_val[11], new_val[7], new_val[3]};
                    MTVEC:   mtvec  <= {new_val[31:2], 2'b00};   // direct mode only
                    MEPC:    mepc   <= {new_val[31:2], 2'b00};
                    MCAUSE:  mcause <= new_val;
                    MTVAL:   mtval  <= new_val;
                    default: ;
                endcase
            end
            // trap and mret come last so they override a csr write on the same edge
            if (trap.take) begin
                mepc         <= trap.epc;
                mcause       <= trap.cause;
                mtval        <= trap.tval;
                mstatus.mpp  <= curr_mode;
                mstatus.mpie <= mstatus.mie;
                mstatus.mie  <= 1'b0;
                curr_mode    <= M_MODE;
            end else if (trap.mret) begin
                curr_mode    <= mstatus.mpp;
                mstatus.mie  <= mstatus.mpie;
                mstatus.mpie <= 1'b1;
                mstatus.mpp  <= U_MODE;
            end
        end
    end

endmodule

`default_nettype wire

/* priv_block/priv_trap_ctrl.sv */
/* merges protection faults, pipeline exceptions and interrupts into one
   prioritized trap, registers the one-cycle PC redirect */
`timescale 1ns/1ns
`default_nettype none

module priv_trap_ctrl import priv_types_pkg::*, mem_prot_pkg::*; (
    input  logic        CLK,
    input  logic        rst,
    input  exc_t        exc,
    input  prot_res_t   pma_res,
    input  prot_res_t   pmp_res,
    input  mem_acc_t    iacc,
    input  mem_acc_t    dacc,
    input  logic [2:0]  int_pending,  // {ext, timer, soft}
    input  logic [2:0]  mie_en,
    input  mstatus_t    mstatus,
    input  priv_level_t curr_mode,
    input  logic [31:0] mtvec,
    input  logic [31:0] mepc,
    output prot_res_t   prot_fault,
    output trap_t       trap,
    output logic        insert_pc,
    output logic [31:0] priv_pc
);

    logic [2:0] int_ready;
    logic       int_on;
    logic       mret_ok;
    logic       mret_bad;

    assign prot_fault.i_fault = iacc.xen && (pma_res.i_fault || pmp_res.i_fault);
    assign prot_fault.l_fault = dacc.ren && (pma_res.l_fault || pmp_res.l_fault);
    assign prot_fault.s_fault = dacc.wen && (pma_res.s_fault || pmp_res.s_fault);

    assign int_ready = int_pending & mie_en;
    assign int_on    = (|int_ready) && (mstatus.mie || curr_mode == U_MODE);
    assign mret_ok   = exc.valid && exc.mret && curr_mode == M_MODE;
    assign mret_bad  = exc.valid && exc.mret && curr_mode == U_MODE;  // mret from U is illegal

    always_comb begin
        trap      = '0;
        trap.epc  = exc.epc;
        trap.take = 1'b1;
        if (int_on) begin
            trap.is_interrupt = 1'b1;
            trap.cause = int_ready[2] ? CAUSE_EXT_INT  :
                         int_ready[0] ? CAUSE_SOFT_INT : CAUSE_TIMER_INT;
        end else if (prot_fault.i_fault) begin
            trap.cause = CAUSE_INSN_FAULT;
            trap.tval  = iacc.addr;
        end else if (exc.valid && (exc.illegal || mret_bad)) begin
            trap.cause = CAUSE_ILLEGAL;
        end else if (exc.valid && exc.breakpoint) begin
            trap.cause = CAUSE_BREAKPOINT;
        end else if (exc.valid && exc.ecall) begin
            trap.cause = (curr_mode == U_MODE) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
        end else if (prot_fault.l_fault) begin
            trap.cause = CAUSE_LOAD_FAULT;
            trap.tval  = dacc.addr;
        end else if (prot_fault.s_fault) begin
            trap.cause = CAUSE_STORE_FAULT;
            trap.tval  = dacc.addr;
        end else begin
            trap.take = 1'b0;
            trap.mret = mret_ok;
        end
        if (insert_pc) begin   // events in the redirect cycle are dropped
            trap.take = 1'b0;
            trap.mret = 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst)
            insert_pc <= 1'b0;
        else
            insert_pc <= trap.take || trap.mret;
    end

    always_ff @(posedge CLK) begin
        if (trap.take || trap.mret)
            priv_pc <= trap.mret ? mepc : mtvec;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the priv_block testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module priv_block_tb \
    -o priv_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/priv_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* testbench/priv_block_assertions.sv */
/* handshake and redirect pulse assertions, bound into the CSR file
   and the trap controller */
`timescale 1ns/1ns
`default_nettype none

module priv_block_assertions (
    input wire logic CLK,
    input wire logic rst,
    input wire logic csr_valid,
    input wire logic csr_ack,
    input wire logic insert_pc
);

    ack_needs_valid: assert property (@(posedge CLK) disable iff (rst)
        $rose(csr_ack) |-> $past(csr_valid))
        else $error("csr_ack rose without csr_valid");

    ack_follows_drop: assert property (@(posedge CLK) disable iff (rst)
        $fell(csr_valid) |=> !csr_ack)
        else $error("csr_ack late after csr_valid dropped");

    redirect_one_cycle: assert property (@(posedge CLK) disable iff (rst)
        insert_pc |=> !insert_pc)
        else $error("insert_pc held for two cycles");

endmodule

bind priv_csr priv_block_assertions i_handshake_assert (
    .CLK(CLK), .rst(rst), .csr_valid(csr_valid), .csr_ack(csr_ack), .insert_pc(1'b0)
);

bind priv_trap_ctrl priv_block_assertions i_redirect_assert (
    .CLK(CLK), .rst(rst), .csr_valid(1'b0), .csr_ack(1'b0), .insert_pc(insert_pc)
);

`default_nettype wire

/* testbench/priv_block_tb.sv */
/* testbench for priv_block: clock, reset, file-driven CSR, access,
   exception and interrupt tests, timeout and error summary */
`timescale 1ns/1ns
`default_nettype none

module priv_block_tb import priv_types_pkg::*, mem_prot_pkg::*;;

    logic        CLK;
    logic        rst;
    logic        csr_valid;
    csr_req_t    csr_req;
    logic        csr_ack;
    csr_rsp_t    csr_rsp;
    mem_acc_t    iacc;
    mem_acc_t    dacc;
    prot_res_t   prot_fault;
    exc_t        exc;
    logic        timer_int;
    logic        soft_int;
    logic        ext_int;
    logic        insert_pc;
    logic [31:0] priv_pc;
    priv_level_t curr_mode;

    int          value_errs = 0;
    int          other_errs = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state;
    logic [31:0] mtvec_exp;   // trap target expected after the csr tests so far

    // one entry per stimulus line
    string       kinds[$];
    string       names[$];
    logic [31:0] op_a[$];
    logic [31:0] op_b[$];
    logic [31:0] op_c[$];
    logic [31:0] exp_1[$];
    logic [31:0] exp_2[$];

    priv_block i_priv_block (
        .CLK(CLK), .rst(rst),
        .csr_valid(csr_valid), .csr_req(csr_req), .csr_ack(csr_ack), .csr_rsp(csr_rsp),
        .iacc(iacc), .dacc(dacc), .prot_fault(prot_fault), .exc(exc),
        .timer_int(timer_int), .soft_int(soft_int), .ext_int(ext_int),
        .insert_pc(insert_pc), .priv_pc(priv_pc), .curr_mode(curr_mode)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("run stopped: no progress after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Error %s: expected %h, actual %h", name, exp, act);
        value_errs++;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] e1;
        logic [31:0] e2;
        fd = $fopen("testbench/priv_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h", kind, name, a, b, c, e1, e2);
                if (n == 7) begin
                    kinds.push_back(kind);
                    names.push_back(name);
                    op_a.push_back(a);
                    op_b.push_back(b);
                    op_c.push_back(c);
                    exp_1.push_back(e1);
                    exp_2.push_back(e2);
                end else begin
                    $display("malformed stimulus line: %s", line);
                    other_errs++;
                end
            end
        end
        $fclose(fd);
    endtask

    // watch for the one-cycle redirect, sampled mid-cycle
    task automatic wait_redirect(input int max_cycles, output logic found);
        found = 1'b0;
        for (int k = 0; k < max_cycles && !found; k++) begin
            @(negedge CLK);
            if (insert_pc)
                found = 1'b1;
        end
    endtask

    // a = address, b = op, c = wdata; expects rdata and err
    task automatic run_csr(input string name, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] c, input logic [31:0] e1, input logic [31:0] e2);
        logic        seen;
        logic [31:0] wdata;
        seen  = 1'b0;
        wdata = (b == 32'd0) ? lcg_next() : c;   // reads carry junk data
        @(posedge CLK);
        csr_valid <= 1'b1;
        csr_req   <= '{addr: a[11:0], op: csr_op_t'(b[1:0]), wdata: wdata};
        for (int k = 0; k < 4 && !seen; k++) begin
            @(negedge CLK);
            seen = csr_ack;
        end
        if (!seen) begin
            $display("%s: csr_ack never came", name);
            other_errs++;
        end
        if (csr_rsp.rdata !== e1)
            report_mismatch({name, " rdata"}, e1, csr_rsp.rdata);
        if (csr_rsp.err !== e2[0])
            report_mismatch({name, " err"}, e2, {31'd0, csr_rsp.err});
        if (a[11:0] == MTVEC && e2[0] == 1'b0) begin   // direct mode keeps bits 1:0 clear
            case (b[1:0])
                2'd1:    mtvec_exp = c;
                2'd2:    mtvec_exp = mtvec_exp | c;
                2'd3:    mtvec_exp = mtvec_exp & ~c;
                default: ;
            endcase
            mtvec_exp[1:0] = 2'b00;
        end
        @(posedge CLK);
        csr_valid <= 1'b0;
        for (int k = 0; k < 4 && seen; k++) begin
            @(negedge CLK);
            seen = csr_ack;
        end
        if (seen) begin
            $display("%s: csr_ack stayed high after csr_valid dropped", name);
            other_errs++;
        end
    endtask

    // a = address, b = {xen, wen, ren}, c = width; expects {i, l, s} faults
    task automatic run_acc(input string name, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] c, input logic [31:0] e1);
        logic found;
        @(posedge CLK);
        if (b[2])
            iacc <= '{addr: a, width: c[1:0], ren: 1'b0, wen: 1'b0, xen: 1'b1};
        else
            dacc <= '{addr: a, width: c[1:0], ren: b[0], wen: b[1], xen: 1'b0};
        @(negedge CLK);
        if (prot_fault !== e1[2:0])
            report_mismatch(name, e1, {29'd0, prot_fault});
        @(posedge CLK);
        iacc <= '0;
        dacc <= '0;
        if (e1[2:0] != 3'b000) begin   // a fault traps
            wait_redirect(1, found);
            if (!found) begin
                $display("%s: no redirect in the cycle after the access fault", name);
                other_errs++;
            end else if (priv_pc !== mtvec_exp) begin
                report_mismatch({name, " priv_pc"}, mtvec_exp, priv_pc);
            end
            @(posedge CLK);
        end
    endtask

    // a = {mret, ecall, breakpoint, illegal}, b = epc; expects priv_pc and mode
    task automatic run_exc(input string name, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] e1, input logic [31:0] e2);
        logic found;
        @(posedge CLK);
        exc <= '{valid: 1'b1, illegal: a[0], breakpoint: a[1], ecall: a[2], mret: a[3],
                 epc: b, badaddr: lcg_next()};
        @(posedge CLK);
        exc <= '0;
        wait_redirect(1, found);
        if (!found) begin
            $display("%s: no redirect in the cycle after the exception", name);
            other_errs++;
        end
        if (priv_pc !== e1)
            report_mismatch({name, " priv_pc"}, e1, priv_pc);
        if (curr_mode !== priv_level_t'(e2[1:0]))
            report_mismatch({name, " mode"}, e2, {30'd0, curr_mode});
        @(posedge CLK);
    endtask

    // a = {ext, timer, soft}; expects priv_pc and whether a trap is taken
    task automatic run_irq(input string name, input logic [31:0] a,
                           input logic [31:0] e1, input logic [31:0] e2);
        logic found;
        @(posedge CLK);
        {ext_int, timer_int, soft_int} <= a[2:0];
        wait_redirect(6, found);
        if (found !== e2[0])
            report_mismatch({name, " taken"}, e2, {31'd0, found});
        if (found && priv_pc !== e1)
            report_mismatch({name, " priv_pc"}, e1, priv_pc);
        @(posedge CLK);
        {ext_int, timer_int, soft_int} <= 3'b000;
        repeat (2) @(posedge CLK);
    endtask

    initial begin
        lcg_state = 32'h9d56;
        mtvec_exp = MTVEC_RESET;
        rst       = 1'b1;
        csr_valid = 1'b0;
        csr_req   = '0;
        iacc      = '0;
        dacc      = '0;
        exc       = '0;
        timer_int = 1'b0;
        soft_int  = 1'b0;
        ext_int   = 1'b0;
        load_stimulus();
        cycle_limit = 40 * kinds.size() + 100;
        repeat (2) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        if (curr_mode !== M_MODE)
            report_mismatch("reset_mode", {30'd0, M_MODE}, {30'd0, curr_mode});
        if (insert_pc !== 1'b0 || prot_fault !== 3'b000) begin
            $display("outputs not idle after reset");
            other_errs++;
        end
        foreach (kinds[i]) begin
            case (kinds[i])
                "csr": run_csr(names[i], op_a[i], op_b[i], op_c[i], exp_1[i], exp_2[i]);
                "acc": run_acc(names[i], op_a[i], op_b[i], op_c[i], exp_1[i]);
                "exc": run_exc(names[i], op_a[i], op_b[i], exp_1[i], exp_2[i]);
                "irq": run_irq(names[i], op_a[i], exp_1[i], exp_2[i]);
                default: begin
                    $display("unknown operation kind %s in line %0d", kinds[i], i);
                    other_errs++;
                end
            endcase
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/priv_stimulus.txt */
# kind name a b c exp1 exp2, all numbers hex
# csr: addr op(0 rd 1 wr 2 set 3 clr) wdata rdata err | acc: addr {x,w,r} width {i,l,s} 0 | exc: {mret,ecall,brk,ill} epc 0 pc mode | irq: {ext,tmr,sw} 0 0 pc taken
csr mtvec_rst 305 0 0 00000100 0
csr mhartid_rd f14 0 0 00000000 0
csr mtvec_wr 305 1 00000200 00000100 0
csr mtvec_set 305 2 00000030 00000200 0
csr mtvec_clr 305 3 00000200 00000230 0
csr mtvec_rd 305 0 0 00000030 0
csr mtvec_wr2 305 1 80000100 00000030 0
csr mhartid_wr f14 1 00001234 00000000 1
acc rom_rd 00000100 1 2 0 0
acc rom_wr 00000100 2 2 1 0
acc io_x 40000010 4 2 4 0
acc io_half 40000010 1 1 2 0
acc io_wr 40000010 2 2 0 0
acc ram_x 80000040 4 2 0 0
acc hole_rd 20000000 1 2 2 0
csr ld_mcause 342 0 0 00000005 0
csr ld_mtval 343 0 0 20000000 0
exc illegal 1 80000010 0 80000100 3
csr il_mcause 342 0 0 00000002 0
csr il_mepc 341 0 0 80000010 0
csr il_mtval 343 0 0 00000000 0
exc ecall 4 80000020 0 80000100 3
csr ec_mcause 342 0 0 0000000b 0
csr pmpaddr0 3b0 1 00004000 00000000 0
csr pmpaddr1 3b1 1 20002000 00000000 0
csr pmpaddr2 3b2 1 20004000 00000000 0
csr pmpcfg0 3a0 1 00890f09 00000000 0
csr pmpcfg_rd 3a0 0 0 00890f09 0
csr lock_rewr 3b2 1 00000000 20004000 0
csr lock_rd 3b2 0 0 20004000 0
acc m_lock_wr 80008000 2 2 1 0
acc m_lock_rd 80008000 1 2 0 0
csr mstatus_wr 300 1 00000080 00001800 0
csr mepc_wr 341 1 80000200 00000000 0
exc mret 8 0 0 80000200 0
csr u_rd 300 0 0 00000000 1
acc u_rom_rd 00000100 1 2 0 0
acc u_ram_wr 80000040 2 2 0 0
acc u_lock_rd 80008000 1 2 0 0
acc u_lock_wr 80008000 2 2 1 0
csr u_mstatus 300 0 0 00000080 0
csr u_mtval 343 0 0 80008000 0
exc mret2 8 0 0 00000000 0
acc u_rom_x 00000100 4 2 4 0
csr x_mcause 342 0 0 00000001 0
exc mret3 8 0 0 00000000 0
exc u_mret 8 0 0 80000100 3
csr um_mcause 342 0 0 00000002 0
csr mie_wr 304 1 00000880 00000000 0
irq masked_m 6 0 0 00000000 0
csr mie_on 300 2 00000008 00000080 0
irq ext_tmr 6 0 0 80000100 1
csr int_mcause 342 0 0 8000000b 0

/* vlog.f */
common/priv_types_pkg.sv
common/mem_prot_pkg.sv
mem_prot/priv_pma.sv
mem_prot/priv_pmp.sv
priv_block/priv_csr.sv
priv_block/priv_trap_ctrl.sv
priv_block/priv_block.sv
testbench/priv_block_assertions.sv
testbench/priv_block_tb.sv
